// ==== fleetPkg.sv ====
`default_nettype none

package fleetPkg;

	// ***********************************************************************
	// Board and cell geometry
	// ***********************************************************************
	localparam int coordWidth = 4;
	localparam int boardSize = 8;
	// One cell is x in the high nibble, y in the low nibble
	localparam int cellWidth = 2 * coordWidth;
	localparam int maxCells = 5;
	localparam int cellsWidth = maxCells * cellWidth;
	localparam int countWidth = 3;

	// ***********************************************************************
	// Ship kinds
	// ***********************************************************************
	localparam int kindWidth = 3;
	localparam logic [kindWidth-1:0] kindSubmarine = 3'd0;
	localparam logic [kindWidth-1:0] kindCruiser = 3'd1;
	localparam logic [kindWidth-1:0] kindHydroplane = 3'd2;
	localparam logic [kindWidth-1:0] kindBattleship = 3'd3;
	localparam logic [kindWidth-1:0] kindCarrier = 3'd4;

	// Fleet storage per player
	localparam int fleetSlots = 12;
	localparam int slotWidth = 4;
	localparam int fleetCountWidth = 5;

	// ***********************************************************************
	// Placement controller states
	// ***********************************************************************
	localparam int stateWidth = 3;
	localparam logic [stateWidth-1:0] stIdle = 3'd0;
	localparam logic [stateWidth-1:0] stCapture = 3'd1;
	localparam logic [stateWidth-1:0] stJudge = 3'd2;
	localparam logic [stateWidth-1:0] stScan = 3'd3;
	localparam logic [stateWidth-1:0] stWrite = 3'd4;
	localparam logic [stateWidth-1:0] stRespond = 3'd5;
	localparam logic [stateWidth-1:0] stRelease = 3'd6;

endpackage

`default_nettype wire

// ==== fleetMemIf.sv ====
`default_nettype none

interface fleetMemIf;

	// Bank select, shared by reads and writes
	logic player;

	// Asynchronous read port
	logic [fleetPkg::slotWidth-1:0] readSlot;
	logic [fleetPkg::cellsWidth-1:0] readCells;
	logic [fleetPkg::countWidth-1:0] readCount;

	// Write port, slot chosen by the bank's own counter
	logic writeEn;
	logic [fleetPkg::cellsWidth-1:0] writeCells;
	logic [fleetPkg::countWidth-1:0] writeCount;

	logic [fleetPkg::fleetCountWidth-1:0] shipCount;

	modport store (
		input player, readSlot, writeEn, writeCells, writeCount,
		output readCells, readCount, shipCount
	);

	modport reader (
		input readCells, readCount, shipCount,
		output readSlot
	);

	modport writer (
		input shipCount,
		output player, writeEn, writeCells, writeCount
	);

endinterface

`default_nettype wire

// ==== shipShaper.sv ====
`default_nettype none

module shipShaper (
	input logic [fleetPkg::kindWidth-1:0] kind,
	input logic [fleetPkg::coordWidth-1:0] x,
	input logic [fleetPkg::coordWidth-1:0] y,
	input logic vertical,
	input logic flip,
	output logic [fleetPkg::cellsWidth-1:0] cells,
	output logic [fleetPkg::countWidth-1:0] count,
	output logic fits
);

	logic [fleetPkg::coordWidth-1:0] cellX [fleetPkg::maxCells];
	logic [fleetPkg::coordWidth-1:0] cellY [fleetPkg::maxCells];

	// ***********************************************************************
	// Cell coordinates
	// ***********************************************************************
	always_comb
	begin
		// Straight line from the anchor by default
		for (int i = 0; i < fleetPkg::maxCells; i++)
		begin
			cellX[i] = x + (vertical ? '0 : fleetPkg::coordWidth'(i));
			cellY[i] = y + (vertical ? fleetPkg::coordWidth'(i) : '0);
		end

		// Hydroplane bends at its middle cell
		if (kind == fleetPkg::kindHydroplane)
		begin
			if (!vertical)
			begin
				cellX[1] = x + 1'b1;
				cellY[1] = flip ? y - 1'b1 : y + 1'b1;
				cellX[2] = x + 2'd2;
				cellY[2] = y;
			end
			else
			begin
				cellX[1] = flip ? x - 1'b1 : x + 1'b1;
				cellY[1] = y + 1'b1;
				cellX[2] = x;
				cellY[2] = y + 2'd2;
			end
		end
	end

	// Cells used by each kind
	always_comb
	begin
		case (kind)
			fleetPkg::kindSubmarine: count = fleetPkg::countWidth'(1);
			fleetPkg::kindCruiser: count = fleetPkg::countWidth'(2);
			fleetPkg::kindHydroplane: count = fleetPkg::countWidth'(3);
			fleetPkg::kindBattleship: count = fleetPkg::countWidth'(4);
			fleetPkg::kindCarrier: count = fleetPkg::countWidth'(5);
			default: count = '0;
		endcase
	end

	// ***********************************************************************
	// Border check and packing
	// ***********************************************************************
	always_comb
	begin
		// Unknown kind codes never fit
		fits = (kind <= fleetPkg::kindCarrier);
		cells = '0;
		for (int i = 0; i < fleetPkg::maxCells; i++)
		begin
			if (i < count)
			begin
				cells[i*fleetPkg::cellWidth +: fleetPkg::cellWidth] = {cellX[i], cellY[i]};
				// Wrapped coordinates land past the edge too, since the anchor is checked
				if (cellX[i] >= fleetPkg::boardSize || cellY[i] >= fleetPkg::boardSize)
					fits = 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

// ==== overlapScanner.sv ====
`default_nettype none

module overlapScanner (
	input logic clk,
	input logic rstN,
	input logic start,
	input logic [fleetPkg::cellsWidth-1:0] newCells,
	input logic [fleetPkg::countWidth-1:0] newCount,
	fleetMemIf.reader mem,
	output logic done,
	output logic overlap
);

	logic busy;
	logic [fleetPkg::slotWidth-1:0] slot;
	logic hit;
	logic lastSlot;

	assign mem.readSlot = slot;
	assign lastSlot = (fleetPkg::fleetCountWidth'(slot) + 1'b1) == mem.shipCount;

	// Every used new cell against every used stored cell
	always_comb
	begin
		hit = 1'b0;
		for (int i = 0; i < fleetPkg::maxCells; i++)
		begin
			for (int j = 0; j < fleetPkg::maxCells; j++)
			begin
				if (i < newCount && j < mem.readCount
					&& newCells[i*fleetPkg::cellWidth +: fleetPkg::cellWidth]
					== mem.readCells[j*fleetPkg::cellWidth +: fleetPkg::cellWidth])
					hit = 1'b1;
			end
		end
	end

	// ***********************************************************************
	// Slot walk, one stored ship per cycle
	// ***********************************************************************
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			busy <= 1'b0;
			slot <= '0;
			done <= 1'b0;
			overlap <= 1'b0;
		end
		else
		begin
			done <= 1'b0;
			if (start)
			begin
				slot <= '0;
				overlap <= 1'b0;
				// Empty fleet answers at once
				if (mem.shipCount == '0)
					done <= 1'b1;
				else
					busy <= 1'b1;
			end
			else if (busy)
			begin
				if (hit || lastSlot)
				begin
					busy <= 1'b0;
					done <= 1'b1;
					overlap <= hit;
				end
				else
					slot <= slot + 1'b1;
			end
		end
	end

	// Never read past the ships the store holds for this player
	slotInRange: assert property (@(posedge clk) disable iff (!rstN)
		busy |-> fleetPkg::fleetCountWidth'(mem.readSlot) < mem.shipCount);

endmodule

`default_nettype wire

// ==== fleetStore.sv ====
`default_nettype none

module fleetStore (
	input logic clk,
	input logic rstN,
	fleetMemIf.store mem
);

	logic [fleetPkg::cellsWidth-1:0] cellBank [2][fleetPkg::fleetSlots];
	logic [fleetPkg::countWidth-1:0] countBank [2][fleetPkg::fleetSlots];
	logic [fleetPkg::fleetCountWidth-1:0] shipCounter [2];
	logic [fleetPkg::slotWidth-1:0] writeSlot;

	// Next free slot of the selected bank
	assign writeSlot = shipCounter[mem.player][fleetPkg::slotWidth-1:0];

	// ***********************************************************************
	// Read side
	// ***********************************************************************
	assign mem.readCells = cellBank[mem.player][mem.readSlot];
	assign mem.readCount = countBank[mem.player][mem.readSlot];
	assign mem.shipCount = shipCounter[mem.player];

	// ***********************************************************************
	// Write side
	// ***********************************************************************
	always_ff @(posedge clk)
	begin
		if (mem.writeEn)
		begin
			cellBank[mem.player][writeSlot] <= mem.writeCells;
			countBank[mem.player][writeSlot] <= mem.writeCount;
		end
	end

	// Counters advance with the write
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			shipCounter[0] <= '0;
			shipCounter[1] <= '0;
		end
		else if (mem.writeEn)
			shipCounter[mem.player] <= shipCounter[mem.player] + 1'b1;
	end

	// Controller must report fleet full instead of writing
	noWriteWhenFull: assert property (@(posedge clk) disable iff (!rstN)
		mem.writeEn |-> shipCounter[mem.player] < fleetPkg::fleetSlots);

endmodule

`default_nettype wire

// ==== placementControl.sv ====
`default_nettype none

module placementControl (
	input logic clk,
	input logic rstN,
	input logic req,
	input logic [fleetPkg::kindWidth-1:0] kind,
	input logic player,
	input logic [fleetPkg::coordWidth-1:0] x,
	input logic [fleetPkg::coordWidth-1:0] y,
	input logic vertical,
	input logic flip,
	output logic ack,
	output logic accepted,
	output logic borderFault,
	output logic fleetFull,
	output logic overlapFault,
	output logic [fleetPkg::kindWidth-1:0] shapeKind,
	output logic [fleetPkg::coordWidth-1:0] shapeX,
	output logic [fleetPkg::coordWidth-1:0] shapeY,
	output logic shapeVertical,
	output logic shapeFlip,
	input logic [fleetPkg::cellsWidth-1:0] shapeCells,
	input logic [fleetPkg::countWidth-1:0] shapeCount,
	input logic shapeFits,
	output logic scanStart,
	input logic scanDone,
	input logic scanOverlap,
	fleetMemIf.writer mem
);

	logic [fleetPkg::stateWidth-1:0] state;
	logic capPlayer;
	logic fleetHasRoom;

	// Request fields, held for the whole transaction
	always_ff @(posedge clk)
	begin
		if (state == fleetPkg::stCapture)
		begin
			shapeKind <= kind;
			shapeX <= x;
			shapeY <= y;
			shapeVertical <= vertical;
			shapeFlip <= flip;
			capPlayer <= player;
		end
	end

	assign fleetHasRoom = mem.shipCount < fleetPkg::fleetSlots;
	assign scanStart = (state == fleetPkg::stJudge) && shapeFits && fleetHasRoom;

	assign mem.player = capPlayer;
	assign mem.writeEn = (state == fleetPkg::stWrite);
	assign mem.writeCells = shapeCells;
	assign mem.writeCount = shapeCount;

	// ***********************************************************************
	// Sequencing and handshake
	// ***********************************************************************
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			state <= fleetPkg::stIdle;
			ack <= 1'b0;
			accepted <= 1'b0;
			borderFault <= 1'b0;
			fleetFull <= 1'b0;
			overlapFault <= 1'b0;
		end
		else
		begin
			case (state)
				fleetPkg::stIdle:
				begin
					if (req)
						state <= fleetPkg::stCapture;
				end
				fleetPkg::stCapture:
					state <= fleetPkg::stJudge;
				fleetPkg::stJudge:
				begin
					// Border first, then room in the fleet
					if (!shapeFits)
					begin
						borderFault <= 1'b1;
						ack <= 1'b1;
						state <= fleetPkg::stRespond;
					end
					else if (!fleetHasRoom)
					begin
						fleetFull <= 1'b1;
						ack <= 1'b1;
						state <= fleetPkg::stRespond;
					end
					else
						state <= fleetPkg::stScan;
				end
				fleetPkg::stScan:
				begin
					if (scanDone && scanOverlap)
					begin
						overlapFault <= 1'b1;
						ack <= 1'b1;
						state <= fleetPkg::stRespond;
					end
					else if (scanDone)
						state <= fleetPkg::stWrite;
				end
				fleetPkg::stWrite:
				begin
					accepted <= 1'b1;
					ack <= 1'b1;
					state <= fleetPkg::stRespond;
				end
				fleetPkg::stRespond:
				begin
					// Hold the result until the requester lets go
					if (!req)
					begin
						ack <= 1'b0;
						accepted <= 1'b0;
						borderFault <= 1'b0;
						fleetFull <= 1'b0;
						overlapFault <= 1'b0;
						state <= fleetPkg::stRelease;
					end
				end
				fleetPkg::stRelease:
					state <= fleetPkg::stIdle;
				default:
					state <= fleetPkg::stIdle;
			endcase
		end
	end

	ackHeldWhileReq: assert property (@(posedge clk) disable iff (!rstN)
		ack && req |=> ack);

endmodule

`default_nettype wire

// ==== placementValidator.sv ====
`default_nettype none

module placementValidator (
	input logic clk,
	input logic rstN,
	input logic req,
	input logic [fleetPkg::kindWidth-1:0] kind,
	input logic player,
	input logic [fleetPkg::coordWidth-1:0] x,
	input logic [fleetPkg::coordWidth-1:0] y,
	input logic vertical,
	input logic flip,
	output logic ack,
	output logic accepted,
	output logic borderFault,
	output logic fleetFull,
	output logic overlapFault
);

	logic [fleetPkg::kindWidth-1:0] shapeKind;
	logic [fleetPkg::coordWidth-1:0] shapeX;
	logic [fleetPkg::coordWidth-1:0] shapeY;
	logic shapeVertical;
	logic shapeFlip;
	logic [fleetPkg::cellsWidth-1:0] shapeCells;
	logic [fleetPkg::countWidth-1:0] shapeCount;
	logic shapeFits;
	logic scanStart;
	logic scanDone;
	logic scanOverlap;

	fleetMemIf memIf ();

	// ***********************************************************************
	// Control, shape, scan and storage
	// ***********************************************************************
	placementControl controlInst (
		.clk(clk), .rstN(rstN), .req(req), .kind(kind), .player(player),
		.x(x), .y(y), .vertical(vertical), .flip(flip),
		.ack(ack), .accepted(accepted), .borderFault(borderFault),
		.fleetFull(fleetFull), .overlapFault(overlapFault),
		.shapeKind(shapeKind), .shapeX(shapeX), .shapeY(shapeY),
		.shapeVertical(shapeVertical), .shapeFlip(shapeFlip),
		.shapeCells(shapeCells), .shapeCount(shapeCount), .shapeFits(shapeFits),
		.scanStart(scanStart), .scanDone(scanDone), .scanOverlap(scanOverlap),
		.mem(memIf.writer)
	);

	shipShaper shaperInst (
		.kind(shapeKind), .x(shapeX), .y(shapeY),
		.vertical(shapeVertical), .flip(shapeFlip),
		.cells(shapeCells), .count(shapeCount), .fits(shapeFits)
	);

	overlapScanner scannerInst (
		.clk(clk), .rstN(rstN), .start(scanStart),
		.newCells(shapeCells), .newCount(shapeCount),
		.mem(memIf.reader), .done(scanDone), .overlap(scanOverlap)
	);

	fleetStore storeInst (
		.clk(clk), .rstN(rstN), .mem(memIf.store)
	);

endmodule

`default_nettype wire

// ==== placementChecker.sv ====
`default_nettype none

module placementChecker (
	input logic clk,
	input logic rstN,
	input logic req,
	input logic [fleetPkg::kindWidth-1:0] kind,
	input logic player,
	input logic [fleetPkg::coordWidth-1:0] x,
	input logic [fleetPkg::coordWidth-1:0] y,
	input logic vertical,
	input logic flip,
	input logic ack,
	input logic accepted,
	input logic borderFault,
	input logic fleetFull,
	input logic overlapFault,
	output int testCount,
	output int errorCount
);

	// Result codes, -1 stands for a flag pattern that is not one-hot
	localparam int resAccepted = 0;
	localparam int resBorder = 1;
	localparam int resFull = 2;
	localparam int resOverlap = 3;

	// Reference fleets, coordinates kept as plain integers
	int modelX [2][fleetPkg::fleetSlots][fleetPkg::maxCells];
	int modelY [2][fleetPkg::fleetSlots][fleetPkg::maxCells];
	int modelCount [2][fleetPkg::fleetSlots];
	int modelShips [2];

	// Cells of the request under judgement
	int refX [fleetPkg::maxCells];
	int refY [fleetPkg::maxCells];
	int refCount;

	logic prevAck;
	logic prevReq;
	int tests = 0;
	int errors = 0;

	assign testCount = tests;
	assign errorCount = errors;

	// ***********************************************************************
	// Reference model
	// ***********************************************************************
	function automatic void computeShape(int k, int ax, int ay, logic v, logic f);
		case (k)
			0: refCount = 1;
			1: refCount = 2;
			2: refCount = 3;
			3: refCount = 4;
			4: refCount = 5;
			default: refCount = 0;
		endcase
		for (int i = 0; i < fleetPkg::maxCells; i++)
		begin
			refX[i] = v ? ax : ax + i;
			refY[i] = v ? ay + i : ay;
		end
		// Hydroplane middle cell steps sideways, third cell returns to the line
		if (k == fleetPkg::kindHydroplane)
		begin
			if (!v)
			begin
				refY[1] = f ? ay - 1 : ay + 1;
				refY[2] = ay;
			end
			else
			begin
				refX[1] = f ? ax - 1 : ax + 1;
				refX[2] = ax;
			end
		end
	endfunction

	function automatic int expectedResult(int k, int p, int ax, int ay, logic v, logic f);
		computeShape(k, ax, ay, v, f);
		if (refCount == 0)
			return resBorder;
		for (int i = 0; i < refCount; i++)
		begin
			if (refX[i] < 0 || refX[i] >= fleetPkg::boardSize
				|| refY[i] < 0 || refY[i] >= fleetPkg::boardSize)
				return resBorder;
		end
		if (modelShips[p] >= fleetPkg::fleetSlots)
			return resFull;
		for (int s = 0; s < modelShips[p]; s++)
			for (int j = 0; j < modelCount[p][s]; j++)
				for (int i = 0; i < refCount; i++)
					if (refX[i] == modelX[p][s][j] && refY[i] == modelY[p][s][j])
						return resOverlap;
		return resAccepted;
	endfunction

	function automatic void storeShip(int p);
		for (int i = 0; i < refCount; i++)
		begin
			modelX[p][modelShips[p]][i] = refX[i];
			modelY[p][modelShips[p]][i] = refY[i];
		end
		modelCount[p][modelShips[p]] = refCount;
		modelShips[p]++;
	endfunction

	function automatic string resultName(int r);
		case (r)
			resAccepted: return "accepted";
			resBorder: return "border fault";
			resFull: return "fleet full";
			resOverlap: return "overlap fault";
			default: return "no single result flag";
		endcase
	endfunction

	function automatic void reportError(string msg);
		$display("** Error at time %0t: %s", $time, msg);
		errors++;
	endfunction

	// ***********************************************************************
	// Comparison, sampled just before each rising edge
	// ***********************************************************************
	always @(posedge clk or negedge rstN)
	begin
		int flagSum;
		int expected;
		int observed;
		if (!rstN)
		begin
			modelShips[0] = 0;
			modelShips[1] = 0;
			prevAck = 1'b0;
			prevReq = 1'b0;
		end
		else
		begin
			flagSum = int'(accepted) + int'(borderFault) + int'(fleetFull)
				+ int'(overlapFault);
			if (ack && flagSum != 1)
				reportError($sformatf("%0d result flags high while ack is high", flagSum));
			if (!ack && flagSum != 0)
				reportError($sformatf("%0d result flags high while ack is low", flagSum));
			if (prevAck && prevReq && !ack)
				reportError("ack fell while req was still high");
			if (ack && !prevAck)
			begin
				tests++;
				expected = expectedResult(int'(kind), int'(player), int'(x), int'(y),
					vertical, flip);
				if (flagSum != 1)
					observed = -1;
				else if (accepted)
					observed = resAccepted;
				else if (borderFault)
					observed = resBorder;
				else if (fleetFull)
					observed = resFull;
				else
					observed = resOverlap;
				$display("Test %0d: kind %0d player %0b at (%0d,%0d) vert %0b flip %0b gives %s",
					tests, kind, player, x, y, vertical, flip, resultName(observed));
				if (observed != expected)
					reportError($sformatf("test %0d expected %s, DUT gave %s", tests,
						resultName(expected), resultName(observed)));
				if (expected == resAccepted)
					storeShip(int'(player));
			end
			prevAck = ack;
			prevReq = req;
		end
	end

endmodule

`default_nettype wire

// ==== placementValidatorTb.sv ====
`default_nettype none

module placementValidatorTb;

	localparam int clockPeriod = 20;
	localparam int resetCycles = 4;
	localparam int randomRequests = 300;
	// Pose, border, overlap and fleet-full groups together
	localparam int directedRequests = 72;
	localparam int requestCount = directedRequests + randomRequests;
	localparam int cyclesPerRequest = 40;

	logic clk;
	logic rstN;
	logic req;
	logic [fleetPkg::kindWidth-1:0] kind;
	logic player;
	logic [fleetPkg::coordWidth-1:0] x;
	logic [fleetPkg::coordWidth-1:0] y;
	logic vertical;
	logic flip;
	logic ack;
	logic accepted;
	logic borderFault;
	logic fleetFull;
	logic overlapFault;
	int sentCount;
	int testCount;
	int errorCount;

	placementValidator placementValidator_inst (
		.clk(clk), .rstN(rstN), .req(req), .kind(kind), .player(player),
		.x(x), .y(y), .vertical(vertical), .flip(flip),
		.ack(ack), .accepted(accepted), .borderFault(borderFault),
		.fleetFull(fleetFull), .overlapFault(overlapFault)
	);

	placementChecker resultChecker (
		.clk(clk), .rstN(rstN), .req(req), .kind(kind), .player(player),
		.x(x), .y(y), .vertical(vertical), .flip(flip),
		.ack(ack), .accepted(accepted), .borderFault(borderFault),
		.fleetFull(fleetFull), .overlapFault(overlapFault),
		.testCount(testCount), .errorCount(errorCount)
	);

	initial
	begin
		clk = 1'b0;
		forever #(clockPeriod / 2) clk = ~clk;
	end

	// ***********************************************************************
	// Stimulus tasks
	// ***********************************************************************
	task automatic applyReset();
		@(negedge clk);
		rstN = 1'b0;
		repeat (resetCycles) @(negedge clk);
		rstN = 1'b1;
	endtask

	// Four-phase request, fields held until ack has fallen
	task automatic sendRequest(input int k, input int p, input int ax, input int ay,
		input int v, input int f);
		@(negedge clk);
		kind = fleetPkg::kindWidth'(k);
		player = (p != 0);
		x = fleetPkg::coordWidth'(ax);
		y = fleetPkg::coordWidth'(ay);
		vertical = (v != 0);
		flip = (f != 0);
		req = 1'b1;
		sentCount++;
		while (!ack)
			@(negedge clk);
		req = 1'b0;
		while (ack)
			@(negedge clk);
	endtask

	// Each of these touches the carrier or the submarine placed first
	task automatic sendOverlapSet(input int p);
		sendRequest(fleetPkg::kindSubmarine, p, 3, 4, 0, 0);
		sendRequest(fleetPkg::kindCruiser, p, 5, 3, 1, 0);
		sendRequest(fleetPkg::kindHydroplane, p, 0, 5, 0, 1);
		sendRequest(fleetPkg::kindBattleship, p, 4, 1, 1, 0);
		sendRequest(fleetPkg::kindCarrier, p, 2, 0, 1, 0);
		sendRequest(fleetPkg::kindCruiser, p, 6, 7, 0, 0);
	endtask

	initial
	begin
		void'($urandom(53));
		rstN = 1'b0;
		req = 1'b0;
		kind = '0;
		player = 1'b0;
		x = '0;
		y = '0;
		vertical = 1'b0;
		flip = 1'b0;
		sentCount = 0;
		repeat (resetCycles) @(negedge clk);
		rstN = 1'b1;

		// Every pose of every kind, for both players, on an empty board
		for (int k = 0; k <= 4; k++)
			for (int pose = 0; pose < 4; pose++)
				if (!(k == 0 && pose != 0) && !(k != 2 && pose >= 2))
				begin
					applyReset();
					sendRequest(k, 0, 2, 2, pose % 2, pose / 2);
					sendRequest(k, 1, 2, 2, pose % 2, pose / 2);
				end

		// Just past each edge, then cells shared with the rejected ones
		applyReset();
		sendRequest(fleetPkg::kindSubmarine, 0, 8, 0, 0, 0);
		sendRequest(fleetPkg::kindSubmarine, 0, 0, 8, 0, 0);
		sendRequest(fleetPkg::kindCruiser, 0, 7, 3, 0, 0);
		sendRequest(fleetPkg::kindCruiser, 0, 3, 7, 1, 0);
		sendRequest(fleetPkg::kindBattleship, 0, 5, 1, 0, 0);
		sendRequest(fleetPkg::kindBattleship, 0, 1, 5, 1, 0);
		sendRequest(fleetPkg::kindCarrier, 0, 4, 0, 0, 0);
		sendRequest(fleetPkg::kindCarrier, 0, 0, 4, 1, 0);
		sendRequest(fleetPkg::kindHydroplane, 0, 2, 7, 0, 0);
		sendRequest(fleetPkg::kindHydroplane, 0, 2, 0, 0, 1);
		sendRequest(fleetPkg::kindHydroplane, 0, 7, 2, 1, 0);
		sendRequest(fleetPkg::kindHydroplane, 0, 0, 2, 1, 1);
		for (int k = 5; k < 8; k++)
			sendRequest(k, 0, 2, 2, 0, 0);
		sendRequest(fleetPkg::kindCarrier, 0, 3, 0, 0, 0);
		sendRequest(fleetPkg::kindCarrier, 0, 0, 3, 1, 0);
		sendRequest(fleetPkg::kindHydroplane, 0, 2, 6, 0, 0);
		sendRequest(fleetPkg::kindCruiser, 0, 6, 3, 0, 0);
		sendRequest(fleetPkg::kindBattleship, 0, 1, 4, 1, 0);

		// Overlaps for player 0, same cells free for player 1
		applyReset();
		sendRequest(fleetPkg::kindCarrier, 0, 1, 4, 0, 0);
		sendRequest(fleetPkg::kindSubmarine, 0, 7, 7, 0, 0);
		sendOverlapSet(0);
		sendOverlapSet(1);

		// Twelve ships fill player 0, border still wins over fleet full
		applyReset();
		for (int i = 0; i < fleetPkg::fleetSlots; i++)
			sendRequest(fleetPkg::kindSubmarine, 0, i % 8, i / 8, 0, 0);
		sendRequest(fleetPkg::kindSubmarine, 0, 5, 5, 0, 0);
		sendRequest(fleetPkg::kindSubmarine, 0, 8, 0, 0, 0);
		sendRequest(fleetPkg::kindSubmarine, 0, 0, 0, 0, 0);
		sendRequest(fleetPkg::kindSubmarine, 1, 5, 5, 0, 0);

		applyReset();
		for (int n = 0; n < randomRequests; n++)
			sendRequest($urandom % 8, $urandom % 2, $urandom % 10, $urandom % 10,
				$urandom % 2, $urandom % 2);

		repeat (2) @(negedge clk);
		$display("Requests sent %0d, results checked %0d, errors %0d",
			sentCount, testCount, errorCount);
		if (sentCount != testCount)
			$display("The checker saw %0d results for %0d requests", testCount, sentCount);
		if (errorCount == 0 && sentCount == testCount)
		begin
			$display("Testbench passed");
		end
		else
		begin
			$display("Testbench failed");
		end
		$finish;
	end

	// Generous bound on the slowest request, resets included
	initial
	begin
		#(requestCount * cyclesPerRequest * clockPeriod);
		$display("Run stopped: the DUT did not finish %0d requests in time", requestCount);
		$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== placementValidator.f ====
fleetPkg.sv
fleetMemIf.sv
shipShaper.sv
overlapScanner.sv
fleetStore.sv
placementControl.sv
placementValidator.sv
placementChecker.sv
placementValidatorTb.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module placementValidatorTb \
		-f placementValidator.f -o simv
	./obj_dir/simv | tee sim.log
	grep -q "^Testbench passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
